//--- rp_pkg.sv
package rp_pkg;

  ////////////////////////////////
  // widths and value types
  ////////////////////////////////

  localparam int SAMPLE_W    = 14;  // ADC / DAC resolution
  localparam int PHASE_W     = 48;  // VCO accumulator width
  localparam int NUM_REGIONS = 8;   // bus regions
  localparam int REGION_LSB  = 20;  // region field is addr[22:20]
  localparam int REGION_W    = 3;

  typedef logic        [SAMPLE_W-1:0]   adc_raw_t;   // negative slope, offset binary
  typedef logic signed [SAMPLE_W-1:0]   sample_t;    // two's complement
  typedef logic        [31:0]           bus_data_t;
  typedef logic        [31:0]           bus_addr_t;
  typedef logic        [REGION_W-1:0]   region_t;
  typedef logic        [PHASE_W-1:0]    phase_t;     // phase and frequency word
  typedef logic        [REGION_LSB-1:0] reg_offs_t;  // register offset inside a region

  // processor side bus, enable pulse + ack
  typedef struct packed {
    bus_addr_t  addr;
    bus_data_t  wdata;
    logic [3:0] sel;  // byte select
    logic       wen;  // one cycle write strobe
    logic       ren;  // one cycle read strobe
  } sys_bus_req_t;

  typedef struct packed {
    bus_data_t rdata;
    logic      err;
    logic      ack;
  } sys_bus_rsp_t;

  ////////////////////////////////
  // address map
  ////////////////////////////////

  localparam region_t REGION_VCO = 3'd2;
  localparam region_t REGION_HK  = 3'd3;

  // regions with a slave behind them, the rest answer from the decoder
  localparam logic [NUM_REGIONS-1:0] REGION_USED = (NUM_REGIONS'(1) << REGION_VCO)
                                                 | (NUM_REGIONS'(1) << REGION_HK);

  localparam reg_offs_t HK_ID        = 20'h00;
  localparam reg_offs_t HK_LOOP      = 20'h04;
  localparam reg_offs_t HK_LED       = 20'h08;
  localparam reg_offs_t HK_OFFS_A    = 20'h0C;
  localparam reg_offs_t HK_OFFS_B    = 20'h10;
  localparam reg_offs_t VCO_FREQ_LO  = 20'h00;
  localparam reg_offs_t VCO_FREQ_HI  = 20'h04;
  localparam reg_offs_t VCO_PHASE_HI = 20'h08;

  ////////////////////////////////
  // reset values and constants
  ////////////////////////////////

  localparam bus_data_t HK_ID_VALUE    = 32'h5250_0A17;
  localparam int        VCO_GAIN_SHIFT = 34;               // ch a lands on phase bits 47:34
  localparam phase_t    VCO_FREQ_RESET = 48'h3333_3333_3333;

  // neg. slope offset binary <-> two's complement, same bit op both ways
  function automatic sample_t raw_to_sample(adc_raw_t raw);
    return sample_t'({raw[SAMPLE_W-1], ~raw[SAMPLE_W-2:0]});
  endfunction

  function automatic adc_raw_t sample_to_raw(sample_t smp);
    return {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};  // 0 -> 14'h1FFF
  endfunction

endpackage

//--- sys_bus_decoder.sv
`timescale 1ns/1ns

module sys_bus_decoder (
  input  rp_pkg::sys_bus_req_t bus_req_i,                          // from master
  output rp_pkg::sys_bus_rsp_t bus_rsp_o,
  output rp_pkg::sys_bus_req_t region_req_o [rp_pkg::NUM_REGIONS], // one per region
  input  rp_pkg::sys_bus_rsp_t region_rsp_i [rp_pkg::NUM_REGIONS]
);

  rp_pkg::region_t      region;                       // selected region
  rp_pkg::sys_bus_rsp_t rsp_mux [rp_pkg::NUM_REGIONS]; // responses incl. fixed ones

  assign region = bus_req_i.addr[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];

  ////////////////////////////////
  // request fan out
  ////////////////////////////////

  for (genvar r = 0; r < rp_pkg::NUM_REGIONS; r++) begin : g_region
    logic hit;

    assign hit = (region == rp_pkg::region_t'(r));

    // addr, wdata and sel broadcast, strobes only to the hit region
    always_comb
    begin
      region_req_o[r]     = bus_req_i;
      region_req_o[r].wen = bus_req_i.wen & hit;
      region_req_o[r].ren = bus_req_i.ren & hit;
    end

    if (rp_pkg::REGION_USED[r]) begin : g_used
      assign rsp_mux[r] = region_rsp_i[r];
    end
    else begin : g_unused
      // empty region, acks at once and reads zero
      assign rsp_mux[r] = '{rdata: '0, err: 1'b0, ack: 1'b1};
    end
  end

  ////////////////////////////////
  // return path
  ////////////////////////////////

  // addr is held until ack, so the mux is stable over the access
  assign bus_rsp_o = rsp_mux[region];

endmodule

//--- hk_regs.sv
`timescale 1ns/1ns

module hk_regs (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::sys_bus_req_t bus_req_i,
  output rp_pkg::sys_bus_rsp_t bus_rsp_o,
  output logic                 digital_loop_o,  // adc inputs fed from dac side
  output logic [7:0]           led_o,
  output rp_pkg::sample_t      offs_a_o,        // manual dac offsets
  output rp_pkg::sample_t      offs_b_o
);

  rp_pkg::reg_offs_t offs;     // register offset in region
  rp_pkg::bus_data_t rdata_d;  // read mux
  rp_pkg::bus_data_t rdata_q;
  logic              ack_q;

  assign offs = bus_req_i.addr[rp_pkg::REGION_LSB-1:0];

  ////////////////////////////////
  // write side
  ////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      offs_a_o       <= '0;
      offs_b_o       <= '0;
    end
    else if (bus_req_i.wen)
    begin
      case (offs)
        rp_pkg::HK_LOOP:   digital_loop_o <= bus_req_i.wdata[0];
        rp_pkg::HK_LED:    led_o          <= bus_req_i.wdata[7:0];
        rp_pkg::HK_OFFS_A: offs_a_o       <= rp_pkg::sample_t'(bus_req_i.wdata[13:0]);
        rp_pkg::HK_OFFS_B: offs_b_o       <= rp_pkg::sample_t'(bus_req_i.wdata[13:0]);
        default: ;  // id is read only, rest unmapped
      endcase
    end
  end

  ////////////////////////////////
  // read side
  ////////////////////////////////

  always_comb
  begin
    case (offs)
      rp_pkg::HK_ID:     rdata_d = rp_pkg::HK_ID_VALUE;
      rp_pkg::HK_LOOP:   rdata_d = {31'd0, digital_loop_o};
      rp_pkg::HK_LED:    rdata_d = {24'd0, led_o};
      rp_pkg::HK_OFFS_A: rdata_d = rp_pkg::bus_data_t'(offs_a_o);  // sign extended
      rp_pkg::HK_OFFS_B: rdata_d = rp_pkg::bus_data_t'(offs_b_o);
      default:           rdata_d = '0;                            // unmapped reads zero
    endcase
  end

  // ack one cycle after the strobe, for reads and writes alike
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req_i.wen | bus_req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
      rdata_q <= rdata_d;  // valid together with ack
  end

  assign bus_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

endmodule

//--- adc_frontend.sv
`timescale 1ns/1ns

module adc_frontend (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::adc_raw_t adc_dat_a_i,     // raw pins, negative slope
  input  rp_pkg::adc_raw_t adc_dat_b_i,
  input  logic             digital_loop_i,
  input  rp_pkg::sample_t  loop_a_i,        // registered dac ch a
  input  rp_pkg::sample_t  loop_b_i,        // vco sawtooth
  output rp_pkg::sample_t  adc_a_o,
  output rp_pkg::sample_t  adc_b_o
);

  rp_pkg::adc_raw_t raw_a_q;  // input register, ideally in the IO block
  rp_pkg::adc_raw_t raw_b_q;

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= rp_pkg::sample_to_raw('0);  // mid scale code
      raw_b_q <= rp_pkg::sample_to_raw('0);
    end
    else
    begin
      raw_a_q <= adc_dat_a_i;
      raw_b_q <= adc_dat_b_i;
    end
  end

  // to two's complement, or dac side values when looped back
  assign adc_a_o = digital_loop_i ? loop_a_i : rp_pkg::raw_to_sample(raw_a_q);
  assign adc_b_o = digital_loop_i ? loop_b_i : rp_pkg::raw_to_sample(raw_b_q);

endmodule

//--- dac_backend.sv
`timescale 1ns/1ns

module dac_backend (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::sample_t  adc_a_i,      // ch a source
  input  rp_pkg::sample_t  vco_b_i,      // ch b source, sawtooth
  input  rp_pkg::sample_t  offs_a_i,     // manual offsets
  input  rp_pkg::sample_t  offs_b_i,
  output rp_pkg::sample_t  dac_a_o,      // registered signed ch a
  output rp_pkg::adc_raw_t dac_dat_a_o,  // to dac pins
  output rp_pkg::adc_raw_t dac_dat_b_o
);

  localparam int SW = rp_pkg::SAMPLE_W;

  logic signed [SW:0] sum_a;   // one guard bit
  rp_pkg::sample_t    sat_a;
  rp_pkg::sample_t    sum_b;   // wraps like the sawtooth
  rp_pkg::sample_t    dac_a_q;

  ////////////////////////////////
  // offset add
  ////////////////////////////////

  assign sum_a = adc_a_i + offs_a_i;  // both sign extended to 15 bits

  always_comb
  begin
    if (sum_a[SW] != sum_a[SW-1])
    begin
      // overflow, clip by sign of the true sum
      sat_a = sum_a[SW] ? {1'b1, {(SW-1){1'b0}}}   // -8192
                        : {1'b0, {(SW-1){1'b1}}};  // +8191
    end
    else
    begin
      sat_a = sum_a[SW-1:0];
    end
  end

  assign sum_b = vco_b_i + offs_b_i;  // modulo 2^14

  ////////////////////////////////
  // output registers
  ////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_a_q     <= '0;
      dac_dat_a_o <= rp_pkg::sample_to_raw('0);  // 14'h1FFF
      dac_dat_b_o <= rp_pkg::sample_to_raw('0);
    end
    else
    begin
      dac_a_q     <= sat_a;
      dac_dat_a_o <= rp_pkg::sample_to_raw(sat_a);  // back to negative slope
      dac_dat_b_o <= rp_pkg::sample_to_raw(sum_b);
    end
  end

  assign dac_a_o = dac_a_q;  // for loopback and vco

endmodule

//--- internal_vco.sv
`timescale 1ns/1ns

module internal_vco (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::sample_t      dac_a_i,    // tuning input
  input  rp_pkg::sys_bus_req_t bus_req_i,
  output rp_pkg::sys_bus_rsp_t bus_rsp_o,
  output rp_pkg::sample_t      phase_o     // top phase bits, sawtooth
);

  localparam int PW = rp_pkg::PHASE_W;

  rp_pkg::reg_offs_t offs;
  rp_pkg::phase_t    freq_offs_q;  // bus programmable offset
  rp_pkg::phase_t    freq_q;       // gain scaled ch a + offset
  rp_pkg::phase_t    phase_q;      // accumulator
  rp_pkg::bus_data_t rdata_d;
  rp_pkg::bus_data_t rdata_q;
  logic              ack_q;

  assign offs = bus_req_i.addr[rp_pkg::REGION_LSB-1:0];

  ////////////////////////////////
  // frequency and phase
  ////////////////////////////////

  // freq in counts, f_out = freq / 2^48 * f_clk
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freq_q  <= '0;
      phase_q <= '0;
    end
    else
    begin
      freq_q  <= (rp_pkg::phase_t'(dac_a_i) << rp_pkg::VCO_GAIN_SHIFT) + freq_offs_q;
      phase_q <= phase_q + freq_q;  // free running wrap
    end
  end

  assign phase_o = rp_pkg::sample_t'(phase_q[PW-1 -: rp_pkg::SAMPLE_W]);  // bits 47:34

  ////////////////////////////////
  // bus registers
  ////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      freq_offs_q <= rp_pkg::VCO_FREQ_RESET;
    else if (bus_req_i.wen)
    begin
      case (offs)
        rp_pkg::VCO_FREQ_LO: freq_offs_q[31:0]    <= bus_req_i.wdata;
        rp_pkg::VCO_FREQ_HI: freq_offs_q[PW-1:32] <= bus_req_i.wdata[PW-33:0];
        default: ;  // phase is read only
      endcase
    end
  end

  always_comb
  begin
    case (offs)
      rp_pkg::VCO_FREQ_LO:  rdata_d = freq_offs_q[31:0];
      rp_pkg::VCO_FREQ_HI:  rdata_d = {16'd0, freq_offs_q[PW-1:32]};
      rp_pkg::VCO_PHASE_HI: rdata_d = phase_q[PW-1:16];
      default:              rdata_d = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req_i.wen | bus_req_i.ren;  // one cycle after strobe
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
      rdata_q <= rdata_d;
  end

  assign bus_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

endmodule

//--- red_pitaya_top.sv
`timescale 1ns/1ns

module red_pitaya_top (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::adc_raw_t     adc_dat_a_i,  // adc ch1
  input  rp_pkg::adc_raw_t     adc_dat_b_i,  // adc ch2
  input  rp_pkg::sys_bus_req_t bus_req_i,    // processor bus
  output rp_pkg::sys_bus_rsp_t bus_rsp_o,
  output rp_pkg::adc_raw_t     dac_dat_a_o,
  output rp_pkg::adc_raw_t     dac_dat_b_o,
  output logic [7:0]           led_o
);

  // bus regions, only the vco and hk entries carry a slave
  rp_pkg::sys_bus_req_t region_req [rp_pkg::NUM_REGIONS];
  rp_pkg::sys_bus_rsp_t region_rsp [rp_pkg::NUM_REGIONS];

  logic            digital_loop;
  rp_pkg::sample_t offs_a;
  rp_pkg::sample_t offs_b;
  rp_pkg::sample_t adc_a;     // converted ch a
  rp_pkg::sample_t dac_a;     // registered signed ch a
  rp_pkg::sample_t vco_phase; // sawtooth

  ////////////////////////////////
  // bus decode
  ////////////////////////////////

  sys_bus_decoder i_dec (
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .region_req_o (region_req),
    .region_rsp_i (region_rsp)
  );

  hk_regs i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .bus_req_i      (region_req[rp_pkg::REGION_HK]),
    .bus_rsp_o      (region_rsp[rp_pkg::REGION_HK]),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .offs_a_o       (offs_a),
    .offs_b_o       (offs_b)
  );

  ////////////////////////////////
  // sample path
  ////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_a),      // ch a ramps by its offset in loopback
    .loop_b_i       (vco_phase),  // looped ch b sees the sawtooth
    .adc_a_o        (adc_a),
    .adc_b_o        ()            // no consumer, dac b is fed by the vco
  );

  internal_vco i_vco (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .dac_a_i   (dac_a),
    .bus_req_i (region_req[rp_pkg::REGION_VCO]),
    .bus_rsp_o (region_rsp[rp_pkg::REGION_VCO]),
    .phase_o   (vco_phase)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_a_i     (adc_a),
    .vco_b_i     (vco_phase),
    .offs_a_i    (offs_a),
    .offs_b_i    (offs_b),
    .dac_a_o     (dac_a),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

//--- tb_red_pitaya_top.sv
`timescale 1ns/1ns

module tb_red_pitaya_top;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_RAND, OP_RAMP, OP_SAW, OP_PHASE} op_e;

  // one table entry, data holds the cycle count for sample phases
  typedef struct packed {
    op_e               op;
    rp_pkg::bus_addr_t addr;
    rp_pkg::bus_data_t data;
    rp_pkg::bus_data_t exp;
  } step_t;

  logic                 adc_clk;
  logic                 rst_n;
  rp_pkg::adc_raw_t     adc_dat_a;
  rp_pkg::adc_raw_t     adc_dat_b;
  rp_pkg::adc_raw_t     dac_dat_a;
  rp_pkg::adc_raw_t     dac_dat_b;
  rp_pkg::sys_bus_req_t bus_req;
  rp_pkg::sys_bus_rsp_t bus_rsp;
  logic [7:0]           led;

  step_t             steps [$];
  logic [31:0]       rnd;                 // xorshift state
  int                offs_a_m;            // model of offset a
  logic [7:0]        led_m;               // model of the led register
  rp_pkg::bus_data_t last_phase;
  int                bus_errs;
  int                smp_errs;
  int                n_checks;
  int                cycles;
  int                cycle_limit;

  red_pitaya_top dut_i (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .led_o       (led)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 4 ns period
  end

  // watchdog, limit set once the table is built
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("checks: %0d, bus errors: %0d, sample errors: %0d", n_checks, bus_errs, smp_errs);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////
  // model helpers
  ////////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // top bit kept, rest inverted
  function automatic int code_to_value(input logic [13:0] code);
    logic signed [13:0] v;
    v = code ^ 14'h1FFF;
    return v;
  endfunction

  function automatic logic [13:0] value_to_code(input int v);
    logic [13:0] t;
    t = v[13:0];
    return t ^ 14'h1FFF;
  endfunction

  function automatic int clip14(input int v);
    if (v > 8191)
      return 8191;
    else if (v < -8192)
      return -8192;
    return v;
  endfunction

  function automatic rp_pkg::bus_addr_t hk(input rp_pkg::reg_offs_t o);
    return (rp_pkg::bus_addr_t'(rp_pkg::REGION_HK) << rp_pkg::REGION_LSB) | o;
  endfunction

  function automatic rp_pkg::bus_addr_t vco(input rp_pkg::reg_offs_t o);
    return (rp_pkg::bus_addr_t'(rp_pkg::REGION_VCO) << rp_pkg::REGION_LSB) | o;
  endfunction

  // registered slaves ack one cycle late, empty regions at once
  function automatic int ack_latency(input rp_pkg::bus_addr_t addr);
    rp_pkg::region_t r;
    r = addr[22:20];
    return (r == rp_pkg::REGION_HK || r == rp_pkg::REGION_VCO) ? 1 : 0;
  endfunction

  function automatic void add_step(input op_e op, input rp_pkg::bus_addr_t addr,
                                   input rp_pkg::bus_data_t data, input rp_pkg::bus_data_t exp);
    steps.push_back('{op, addr, data, exp});
  endfunction

  ////////////////////////////////
  // checks and bus access
  ////////////////////////////////

  task automatic check_value(input string name, input rp_pkg::bus_data_t got,
                             input rp_pkg::bus_data_t exp, input bit sample_path);
    n_checks++;
    assert (got === exp)
    else
    begin
      if (sample_path)
        smp_errs++;
      else
        bus_errs++;
      $display("Error: %s expected 0x%08h got 0x%08h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_ack(input rp_pkg::bus_addr_t addr, input int lat);
    n_checks++;
    assert (lat == ack_latency(addr))
    else
    begin
      bus_errs++;
      $display("ack for address 0x%08h came %0d cycles after the strobe instead of %0d",
               addr, lat, ack_latency(addr));
    end
  endtask

  task automatic bus_op(input bit wr, input rp_pkg::bus_addr_t addr,
                        input rp_pkg::bus_data_t wdata,
                        output rp_pkg::bus_data_t rdata, output int lat);
    lat = 0;
    @(posedge adc_clk);
    bus_req.addr  <= addr;   // held until ack
    bus_req.wdata <= wdata;
    bus_req.sel   <= 4'hF;
    bus_req.wen   <= wr;
    bus_req.ren   <= !wr;
    @(negedge adc_clk);
    while (!bus_rsp.ack)
    begin
      @(posedge adc_clk);
      bus_req.wen <= 1'b0;   // strobe lasts one cycle
      bus_req.ren <= 1'b0;
      @(negedge adc_clk);
      lat++;
    end
    rdata = bus_rsp.rdata;  // valid with ack
    check_value("bus_rsp_o.err", bus_rsp.err, '0, 1'b0);  // no region flags errors
    @(posedge adc_clk);
    bus_req.wen <= 1'b0;
    bus_req.ren <= 1'b0;
  endtask

  ////////////////////////////////
  // sample path phases
  ////////////////////////////////

  // raw in at edge k, on the dac pins after edge k+1
  task automatic run_random(input int n);
    logic [13:0] exp_q [$];
    logic [13:0] raw;
    for (int i = 0; i < n + 2; i++)
    begin
      @(posedge adc_clk);
      rnd = next_random(rnd);
      raw = rnd[13:0];
      adc_dat_a <= raw;
      adc_dat_b <= rnd[29:16];
      exp_q.push_back(value_to_code(clip14(code_to_value(raw) + offs_a_m)));
      @(negedge adc_clk);
      if (i >= 2)
        check_value("dac_dat_a_o", dac_dat_a, exp_q.pop_front(), 1'b1);
    end
  endtask

  // loopback, each sample is the clipped previous one plus offset a
  task automatic run_ramp(input int n, input int final_v);
    int prev;
    int cur;
    @(negedge adc_clk);
    prev = code_to_value(dac_dat_a);
    cur  = prev;
    repeat (n)
    begin
      @(negedge adc_clk);
      cur = code_to_value(dac_dat_a);
      check_value("dac_dat_a_o step", cur, clip14(prev + offs_a_m), 1'b1);
      prev = cur;
    end
    check_value("dac_dat_a_o limit", cur, final_v, 1'b1);
  endtask

  task automatic run_saw(input int n, input int step);
    int prev;
    int cur;
    @(posedge adc_clk);
    adc_dat_a <= 14'h1FFF;  // signed zero, freq is the offset alone
    repeat (6) @(negedge adc_clk);  // pipeline settles
    prev = code_to_value(dac_dat_b);
    repeat (n)
    begin
      @(negedge adc_clk);
      cur = code_to_value(dac_dat_b);
      check_value("dac_dat_b_o step", (cur - prev) & 32'h3FFF, step, 1'b1);
      prev = cur;
    end
  endtask

  ////////////////////////////////
  // stimulus table and main loop
  ////////////////////////////////

  initial
  begin
    step_t             st;
    rp_pkg::bus_data_t rdata;
    int                lat;

    rst_n      = 1'b0;
    adc_dat_a  = 14'h1FFF;
    adc_dat_b  = 14'h1FFF;
    bus_req    = '0;
    rnd        = 32'he5183304;
    offs_a_m   = 0;
    led_m      = '0;
    last_phase = '0;
    bus_errs   = 0;
    smp_errs   = 0;
    n_checks   = 0;
    cycles     = 0;

    add_step(OP_RD,    hk(rp_pkg::HK_ID),         '0, rp_pkg::HK_ID_VALUE);
    add_step(OP_RD,    vco(rp_pkg::VCO_FREQ_LO),  '0, 32'h3333_3333);  // reset offset
    add_step(OP_RD,    vco(rp_pkg::VCO_FREQ_HI),  '0, 32'h0000_3333);
    add_step(OP_WR,    hk(rp_pkg::HK_LED),        32'h0000_00A5, '0);
    add_step(OP_RD,    hk(rp_pkg::HK_LED),        '0, 32'h0000_00A5);
    add_step(OP_WR,    hk(rp_pkg::HK_OFFS_A),     32'h0000_0FFF, '0);  // +4095
    add_step(OP_RD,    hk(rp_pkg::HK_OFFS_A),     '0, 32'h0000_0FFF);
    add_step(OP_WR,    hk(rp_pkg::HK_OFFS_B),     32'h0000_2ABC, '0);
    add_step(OP_RD,    hk(rp_pkg::HK_OFFS_B),     '0, 32'hFFFF_EABC);  // sign extended
    add_step(OP_WR,    vco(rp_pkg::VCO_FREQ_LO),  32'h1234_5678, '0);
    add_step(OP_RD,    vco(rp_pkg::VCO_FREQ_LO),  '0, 32'h1234_5678);
    add_step(OP_WR,    vco(rp_pkg::VCO_FREQ_HI),  32'h0000_9ABC, '0);
    add_step(OP_RD,    vco(rp_pkg::VCO_FREQ_HI),  '0, 32'h0000_9ABC);
    add_step(OP_RD,    32'h0000_0004,             '0, '0);             // empty regions
    add_step(OP_RD,    32'h0050_0000,             '0, '0);
    add_step(OP_RD,    32'h0070_0010,             '0, '0);
    add_step(OP_RD,    hk(20'h14),                '0, '0);             // unmapped hk register
    add_step(OP_RAND,  '0,                        32, '0);             // clips high
    add_step(OP_WR,    hk(rp_pkg::HK_OFFS_A),     32'h0000_3000, '0);  // -4096
    add_step(OP_RAND,  '0,                        32, '0);             // clips low
    add_step(OP_WR,    hk(rp_pkg::HK_OFFS_A),     32'h0000_0200, '0);
    add_step(OP_WR,    hk(rp_pkg::HK_LOOP),       32'h1, '0);
    add_step(OP_RAMP,  '0,                        36, 32'h0000_1FFF);
    add_step(OP_WR,    hk(rp_pkg::HK_OFFS_A),     32'h0000_3E00, '0);  // -512
    add_step(OP_RAMP,  '0,                        36, 32'hFFFF_E000);
    add_step(OP_WR,    hk(rp_pkg::HK_LOOP),       32'h0, '0);
    add_step(OP_WR,    hk(rp_pkg::HK_OFFS_A),     32'h0, '0);
    add_step(OP_WR,    vco(rp_pkg::VCO_FREQ_LO),  32'h0, '0);
    add_step(OP_WR,    vco(rp_pkg::VCO_FREQ_HI),  32'h0000_0014, '0);  // freq >> 34 = 5
    add_step(OP_PHASE, vco(rp_pkg::VCO_PHASE_HI), '0, '0);
    add_step(OP_SAW,   '0,                        24, 32'd5);
    add_step(OP_WR,    vco(rp_pkg::VCO_FREQ_HI),  32'h0000_FFFC, '0);  // step wraps to 0x3fff
    add_step(OP_SAW,   '0,                        24, 32'h3FFF);
    add_step(OP_PHASE, vco(rp_pkg::VCO_PHASE_HI), '0, '0);
    cycle_limit = 2 * steps.size() * 20;

    repeat (3) @(posedge adc_clk);
    rst_n <= 1'b1;
    @(negedge adc_clk);
    check_value("led_o", led, '0, 1'b0);
    check_value("dac_dat_a_o", dac_dat_a, 32'h1FFF, 1'b1);
    check_value("dac_dat_b_o", dac_dat_b, 32'h1FFF, 1'b1);

    for (int i = 0; i < steps.size(); i++)
    begin
      st = steps[i];
      case (st.op)
        OP_WR:
        begin
          bus_op(1'b1, st.addr, st.data, rdata, lat);
          check_ack(st.addr, lat);
          if (st.addr == hk(rp_pkg::HK_OFFS_A))
            offs_a_m = $signed(st.data[13:0]);
          if (st.addr == hk(rp_pkg::HK_LED))
            led_m = st.data[7:0];
          @(negedge adc_clk);
          check_value("led_o", led, led_m, 1'b0);
        end
        OP_RD:
        begin
          bus_op(1'b0, st.addr, '0, rdata, lat);
          check_ack(st.addr, lat);
          check_value("bus_rsp_o.rdata", rdata, st.exp, 1'b0);
        end
        OP_PHASE:
        begin
          bus_op(1'b0, st.addr, '0, rdata, lat);
          check_ack(st.addr, lat);
          n_checks++;
          assert (rdata != last_phase)
          else
          begin
            bus_errs++;
            $display("vco phase read 0x%08h did not advance", rdata);
          end
          last_phase = rdata;
        end
        OP_RAND: run_random(st.data);
        OP_RAMP: run_ramp(st.data, st.exp);
        OP_SAW:  run_saw(st.data, st.exp);
        default: ;
      endcase
    end

    $display("checks: %0d, bus errors: %0d, sample errors: %0d", n_checks, bus_errs, smp_errs);
    if (bus_errs + smp_errs == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- all.f
rp_pkg.sv
sys_bus_decoder.sv
hk_regs.sv
adc_frontend.sv
dac_backend.sv
internal_vco.sv
red_pitaya_top.sv
tb_red_pitaya_top.sv

//--- Bender.yml
package:
  name: red_pitaya_top

sources:
  - rp_pkg.sv
  - sys_bus_decoder.sv
  - hk_regs.sv
  - adc_frontend.sv
  - dac_backend.sv
  - internal_vco.sv
  - red_pitaya_top.sv
  - target: simulation
    files:
      - tb_red_pitaya_top.sv
